// ==== tb.f ====
rtl/bmu_pkg.sv
rtl/bmu_issue_if.sv
rtl/bmu_lzc.sv
rtl/bmu_bit_count.sv
rtl/bmu_logic_shadd.sv
rtl/bmu_compare.sv
rtl/bmu_result_mux.sv
rtl/bit_manip_unit.sv
dv/bmu_assert.sv
dv/tb_bit_manip_unit.sv

// ==== Bender.yml ====
package:
  name: bit_manip_unit

sources:
  - files:
      - rtl/bmu_pkg.sv
      - rtl/bmu_issue_if.sv
      - rtl/bmu_lzc.sv
      - rtl/bmu_bit_count.sv
      - rtl/bmu_logic_shadd.sv
      - rtl/bmu_compare.sv
      - rtl/bmu_result_mux.sv
      - rtl/bit_manip_unit.sv
  - target: test
    files:
      - dv/bmu_assert.sv
      - dv/tb_bit_manip_unit.sv

// ==== dv/tb_bit_manip_unit.sv ====
// Testbench for the bit manipulation unit with clock, random stimulus, reference model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_bit_manip_unit;

    import bmu_pkg::*;

    localparam int CLK_PERIOD = 20;
    // Reset, reset check, then each test plus its closing edge
    localparam int TOTAL_CYCLES = 4 + 1 + (200 + 300 + 200 + 200 + 400 + 200) + 6;

    logic        clk_i;
    logic        rst_n_i;
    logic        clk_en_i;
    logic        clear_i;
    data_word_t  operand_a_i;
    data_word_t  operand_b_i;
    bmu_group_t  group_i;
    bmu_opcode_t opcode_i;
    logic        valid_i;
    data_word_t  result_o;
    logic        valid_o;

    integer      seed = 84;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    // Expected state after the next edge
    logic        exp_valid = 1'b0;
    data_word_t  exp_result = '0;
    bmu_group_t  exp_group = '0;
    bmu_opcode_t exp_opcode = '0;

    bit_manip_unit UUT (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .clk_en_i    ( clk_en_i    ),
        .clear_i     ( clear_i     ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .group_i     ( group_i     ),
        .opcode_i    ( opcode_i    ),
        .valid_i     ( valid_i     ),
        .result_o    ( result_o    ),
        .valid_o     ( valid_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //======================================================================
    // Reference model
    //======================================================================

    function automatic data_word_t model_result(bmu_group_t grp, bmu_opcode_t op,
                                                data_word_t a, data_word_t b);
        data_word_t res;
        int         idx;
        int         n;
        logic       found;
        res   = '0;
        idx   = b[4:0];
        n     = 0;
        found = 1'b0;
        case (grp)
            GRP_SHADD: res = b + (a << op);
            GRP_LOGIC: begin
                case (op)
                    LOGIC_ANDN: res = a & ~b;
                    LOGIC_ORN:  res = a | ~b;
                    LOGIC_XNOR: res = ~(a ^ b);
                    LOGIC_BCLR: begin
                        res = a;
                        res[idx] = 1'b0;
                    end
                    LOGIC_BEXT: res = {31'b0, a[idx]};
                    LOGIC_BINV: begin
                        res = a;
                        res[idx] = ~a[idx];
                    end
                    LOGIC_BSET: begin
                        res = a;
                        res[idx] = 1'b1;
                    end
                    default:    res = '0;
                endcase
            end
            GRP_COUNT: begin
                // Zero operand walks the whole word, giving 32
                for (int i = 31; i >= 0; i--) begin
                    if (op == COUNT_CLZ && a[i]) found = 1'b1;
                    if (op == COUNT_CLZ && !found) n++;
                end
                for (int i = 0; i < 32; i++) begin
                    if (op == COUNT_CTZ && a[i]) found = 1'b1;
                    if (op == COUNT_CTZ && !found) n++;
                    if (op == COUNT_CPOP && a[i]) n++;
                end
                res = n;
            end
            default: begin
                case (op)
                    CMP_MAX:  res = ($signed(a) > $signed(b)) ? a : b;
                    CMP_MAXU: res = (a > b) ? a : b;
                    CMP_MIN:  res = ($signed(a) < $signed(b)) ? a : b;
                    CMP_MINU: res = (a < b) ? a : b;
                    default:  res = '0;
                endcase
            end
        endcase
        return res;
    endfunction

    //======================================================================
    // Stimulus helpers
    //======================================================================

    function automatic int rand_below(int n);
        return {$random(seed)} % n;
    endfunction

    // Corner values mixed in with plain random words
    function automatic data_word_t pick_operand();
        case (rand_below(8))
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h1 << rand_below(32);
            default: return $random(seed);
        endcase
    endfunction

    // Legal opcodes only
    function automatic bmu_opcode_t pick_opcode(bmu_group_t grp);
        case (grp)
            GRP_SHADD: return bmu_opcode_t'(1 + rand_below(3));
            GRP_LOGIC: return bmu_opcode_t'(rand_below(7));
            GRP_COUNT: return bmu_opcode_t'(rand_below(3));
            default:   return bmu_opcode_t'(rand_below(4));
        endcase
    endfunction

    // Sampled one ns after the edge, once the stage registers settled
    task automatic check_outputs();
        @(posedge clk_i);
        #1;
        checks++;
        if (valid_o !== exp_valid) begin
            errors++;
            $display("error at %0t: valid_o is %b, expected %b", $time, valid_o, exp_valid);
        end
        if (exp_valid && result_o !== exp_result) begin
            errors++;
            $display("error at %0t: result_o is %h, expected %h (group %0d opcode %0d)",
                     $time, result_o, exp_result, exp_group, exp_opcode);
        end
    endtask

    // Drive one cycle and predict what the next edge commits
    task automatic drive_op(bmu_group_t grp, bmu_opcode_t op, data_word_t a, data_word_t b,
                            logic en, logic clr, logic vld);
        #1;
        group_i     = grp;
        opcode_i    = op;
        operand_a_i = a;
        operand_b_i = b;
        clk_en_i    = en;
        clear_i     = clr;
        valid_i     = vld;
        if (clr) exp_valid = 1'b0;
        else if (en) exp_valid = vld;
        if (en) begin
            exp_result = model_result(grp, op, a, b);
            exp_group  = grp;
            exp_opcode = op;
        end
    endtask

    // Group mode 4 picks a random group every cycle
    task automatic run_test(string name, int grp_mode, int cycles,
                            int en_pct, int clr_pct, int vld_pct);
        int          err_start;
        bmu_group_t  grp;
        bmu_opcode_t op;
        data_word_t  a;
        data_word_t  b;
        err_start = errors;
        for (int c = 0; c < cycles; c++) begin
            check_outputs();
            grp = (grp_mode == 4) ? bmu_group_t'(rand_below(4)) : bmu_group_t'(grp_mode);
            op  = pick_opcode(grp);
            a   = pick_operand();
            b   = pick_operand();
            // Bit indices 0 and 31 for single-bit operations
            if (grp == GRP_LOGIC && rand_below(4) == 0) b[4:0] = rand_below(2) ? 5'd31 : 5'd0;
            // Sign-bit-only difference splits signed from unsigned results
            if (grp == GRP_COMPARE && rand_below(2) == 0) b = a ^ 32'h8000_0000;
            drive_op(grp, op, a, b, rand_below(100) < en_pct, rand_below(100) < clr_pct,
                     rand_below(100) < vld_pct);
        end
        check_outputs();
        tests_run++;
        $display("test %-8s done: %0d cycles, %0d errors", name, cycles, errors - err_start);
    endtask

    //======================================================================
    // Test sequence
    //======================================================================

    initial begin
        rst_n_i     = 1'b0;
        clk_en_i    = 1'b0;
        clear_i     = 1'b0;
        operand_a_i = '0;
        operand_b_i = '0;
        group_i     = '0;
        opcode_i    = '0;
        valid_i     = 1'b0;
        repeat (4) @(posedge clk_i);
        #2 rst_n_i = 1'b1;

        // Nothing issued yet, valid stays low
        check_outputs();
        tests_run++;
        $display("test %-8s done: 1 cycles, %0d errors", "reset", errors);

        run_test("shadd", 0, 200, 100, 0, 100);
        run_test("logic", 1, 300, 100, 0, 100);
        run_test("count", 2, 200, 100, 0, 100);
        run_test("compare", 3, 200, 100, 0, 100);
        run_test("mixed", 4, 400, 70, 0, 80);
        run_test("clear", 4, 200, 50, 10, 90);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the total cycle count of all tests
    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("Run timed out before all tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_bit_manip_unit

`default_nettype wire

// ==== dv/bmu_assert.sv ====
// Concurrent assertions on the valid strobe and result of the output stage, bound to bmu_result_mux
`timescale 1ns/1ps
`default_nettype none

module bmu_assert (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                clk_en_i,
    input  logic                clear_i,
    input  bmu_pkg::data_word_t result_o,
    input  logic                valid_o
);

    // Reset or clear flushes the valid bit at the next edge
    valid_flush: assert property (@(posedge clk_i) (!rst_n_i || clear_i) |=> !valid_o)
        else $error("valid_o high after clear or reset");

    // Stalled cycle keeps the output stage frozen
    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!clk_en_i && !clear_i && valid_o) |=> ($stable(valid_o) && $stable(result_o)))
        else $error("output changed while clk_en_i was low");

    result_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> !$isunknown(result_o))
        else $error("result_o unknown while valid_o high");

endmodule : bmu_assert

bind bmu_result_mux bmu_assert u_bmu_assert (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .clk_en_i ( clk_en_i ),
    .clear_i  ( clear_i  ),
    .result_o ( result_o ),
    .valid_o  ( valid_o  )
);

`default_nettype wire

// ==== rtl/bit_manip_unit.sv ====
// Bit manipulation unit top level wiring ports to the issue interface and groups
`timescale 1ns/1ps
`default_nettype none

module bit_manip_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 clk_en_i,
    input  logic                 clear_i,
    input  bmu_pkg::data_word_t  operand_a_i,
    input  bmu_pkg::data_word_t  operand_b_i,
    input  bmu_pkg::bmu_group_t  group_i,
    input  bmu_pkg::bmu_opcode_t opcode_i,
    input  logic                 valid_i,
    output bmu_pkg::data_word_t  result_o,
    output logic                 valid_o
);

    import bmu_pkg::*;

    // Registered group results
    data_word_t shadd_result;
    data_word_t logic_result;
    data_word_t compare_result;
    bit_count_t count;

    //======================================================================
    // Issue interface
    //======================================================================

    bmu_issue_if issue ();

    // Source side of the interface, straight from the ports
    assign issue.operand_a = operand_a_i;
    assign issue.operand_b = operand_b_i;
    assign issue.opcode    = opcode_i;
    assign issue.clk_en    = clk_en_i;

    //======================================================================
    // Execution groups
    //======================================================================

    bmu_logic_shadd u_logic_shadd (
        .clk_i          ( clk_i        ),
        .issue          ( issue.exec   ),
        .shadd_result_o ( shadd_result ),
        .logic_result_o ( logic_result )
    );

    bmu_bit_count u_bit_count (
        .clk_i   ( clk_i      ),
        .issue   ( issue.exec ),
        .count_o ( count      )
    );

    bmu_compare u_compare (
        .clk_i            ( clk_i          ),
        .issue            ( issue.exec     ),
        .compare_result_o ( compare_result )
    );

    // Group code and valid go straight to the output stage
    bmu_result_mux u_result_mux (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .clk_en_i         ( clk_en_i       ),
        .clear_i          ( clear_i        ),
        .valid_i          ( valid_i        ),
        .group_i          ( group_i        ),
        .shadd_result_i   ( shadd_result   ),
        .logic_result_i   ( logic_result   ),
        .compare_result_i ( compare_result ),
        .count_i          ( count          ),
        .result_o         ( result_o       ),
        .valid_o          ( valid_o        )
    );

endmodule : bit_manip_unit

`default_nettype wire

// ==== rtl/bmu_result_mux.sv ====
// Group-code and valid stage registers with final result selection
`timescale 1ns/1ps
`default_nettype none

module bmu_result_mux (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                clk_en_i,
    input  logic                clear_i,
    input  logic                valid_i,
    input  bmu_pkg::bmu_group_t group_i,
    input  bmu_pkg::data_word_t shadd_result_i,
    input  bmu_pkg::data_word_t logic_result_i,
    input  bmu_pkg::data_word_t compare_result_i,
    input  bmu_pkg::bit_count_t count_i,
    output bmu_pkg::data_word_t result_o,
    output logic                valid_o
);

    import bmu_pkg::*;

    // Group of the operation now held in the unit registers
    bmu_group_t group_q;

    //======================================================================
    // Control stage
    //======================================================================

    // Captured alongside the group results
    always_ff @(posedge clk_i) begin : group_stage
        if (clk_en_i) begin
            group_q <= group_i;
        end
    end : group_stage

    // Clear wins over the enable, so a stalled unit can still be flushed
    always_ff @(posedge clk_i) begin : valid_stage
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end else if (clk_en_i) begin
            valid_o <= valid_i;
        end
    end : valid_stage

    //======================================================================
    // Final selection
    //======================================================================

    always_comb begin : result_select
        case (group_q)
            GRP_SHADD:   result_o = shadd_result_i;
            GRP_LOGIC:   result_o = logic_result_i;
            // Count is zero-extended to a full word
            GRP_COUNT:   result_o = data_word_t'(count_i);
            GRP_COMPARE: result_o = compare_result_i;
            default:     result_o = '0;
        endcase
    end : result_select

endmodule : bmu_result_mux

`default_nettype wire

// ==== rtl/bmu_compare.sv ====
// Signed and unsigned min/max with the compare stage register
`timescale 1ns/1ps
`default_nettype none

module bmu_compare (
    input  logic                clk_i,
    bmu_issue_if.exec           issue,
    output bmu_pkg::data_word_t compare_result_o
);

    import bmu_pkg::*;

    logic       signed_lt;
    logic       unsigned_lt;
    data_word_t compare_d;

    // One decision per signedness, shared by MIN and MAX
    assign signed_lt   = $signed(issue.operand_a) < $signed(issue.operand_b);
    assign unsigned_lt = issue.operand_a < issue.operand_b;

    always_comb begin : minmax_select
        case (issue.opcode)
            CMP_MAX:  compare_d = signed_lt   ? issue.operand_b : issue.operand_a;
            CMP_MAXU: compare_d = unsigned_lt ? issue.operand_b : issue.operand_a;
            CMP_MIN:  compare_d = signed_lt   ? issue.operand_a : issue.operand_b;
            CMP_MINU: compare_d = unsigned_lt ? issue.operand_a : issue.operand_b;
            default:  compare_d = '0;
        endcase
    end : minmax_select

    always_ff @(posedge clk_i) begin : compare_stage
        if (issue.clk_en) begin
            compare_result_o <= compare_d;
        end
    end : compare_stage

endmodule : bmu_compare

`default_nettype wire

// ==== rtl/bmu_logic_shadd.sv ====
// Shift-and-add and logic/single-bit operations with their stage registers
`timescale 1ns/1ps
`default_nettype none

module bmu_logic_shadd (
    input  logic                clk_i,
    bmu_issue_if.exec           issue,
    output bmu_pkg::data_word_t shadd_result_o,
    output bmu_pkg::data_word_t logic_result_o
);

    import bmu_pkg::*;

    data_word_t shadd_d;
    data_word_t logic_d;
    bit_index_t bit_index;
    data_word_t bit_mask;
    data_word_t extract_shift;

    //======================================================================
    // Shift and add
    //======================================================================

    // Opcode value is the shift amount of operand A
    always_comb begin : shadd_logic
        case (issue.opcode)
            3'd0, SHADD_SH1, SHADD_SH2, SHADD_SH3: begin
                shadd_d = issue.operand_b + (issue.operand_a << issue.opcode[1:0]);
            end
            default: shadd_d = '0;
        endcase
    end : shadd_logic

    //======================================================================
    // Logic and single-bit operations
    //======================================================================

    // Bit index from the low bits of operand B
    assign bit_index = issue.operand_b[bmu_index_width-1:0];

    // One-hot mask shared by BCLR, BINV and BSET
    assign bit_mask = data_word_t'(1) << bit_index;

    // BEXT moves the indexed bit down to bit 0
    assign extract_shift = issue.operand_a >> bit_index;

    always_comb begin : logic_select
        case (issue.opcode)
            LOGIC_ANDN: logic_d = issue.operand_a & ~issue.operand_b;
            LOGIC_ORN:  logic_d = issue.operand_a | ~issue.operand_b;
            LOGIC_XNOR: logic_d = ~(issue.operand_a ^ issue.operand_b);
            LOGIC_BCLR: logic_d = issue.operand_a & ~bit_mask;
            LOGIC_BEXT: logic_d = data_word_t'(extract_shift[0]);
            LOGIC_BINV: logic_d = issue.operand_a ^ bit_mask;
            LOGIC_BSET: logic_d = issue.operand_a | bit_mask;
            default:    logic_d = '0;
        endcase
    end : logic_select

    //======================================================================
    // Stage registers
    //======================================================================

    // Both results captured every enabled cycle, group picked later
    always_ff @(posedge clk_i) begin : shadd_stage
        if (issue.clk_en) begin
            shadd_result_o <= shadd_d;
        end
    end : shadd_stage

    always_ff @(posedge clk_i) begin : logic_stage
        if (issue.clk_en) begin
            logic_result_o <= logic_d;
        end
    end : logic_stage

endmodule : bmu_logic_shadd

`default_nettype wire

// ==== rtl/bmu_bit_count.sv ====
// CLZ, CTZ and CPOP evaluation with the count stage register
`timescale 1ns/1ps
`default_nettype none

module bmu_bit_count (
    input  logic                clk_i,
    bmu_issue_if.exec           issue,
    output bmu_pkg::bit_count_t count_o
);

    import bmu_pkg::*;

    data_word_t reversed_a;
    data_word_t lzc_operand;
    lz_count_t  lz_count;
    logic       all_zero;
    bit_count_t pop_count;
    bit_count_t count_d;

    //======================================================================
    // Leading and trailing zeros
    //======================================================================

    // CTZ is CLZ of the bit-reversed operand
    always_comb begin : reverse_operand
        for (int i = 0; i < bmu_data_width; i++) begin
            reversed_a[bmu_data_width-1-i] = issue.operand_a[i];
        end
    end : reverse_operand

    assign lzc_operand = (issue.opcode == COUNT_CTZ) ? reversed_a : issue.operand_a;

    bmu_lzc #(
        .WIDTH ( bmu_data_width )
    ) u_lzc (
        .operand_i  ( lzc_operand ),
        .lz_count_o ( lz_count    ),
        .all_zero_o ( all_zero    )
    );

    // Population count by plain adder chain
    always_comb begin : cpop_adder
        pop_count = '0;
        for (int i = 0; i < bmu_data_width; i++) begin
            pop_count = pop_count + bit_count_t'(issue.operand_a[i]);
        end
    end : cpop_adder

    // Zero operand counts as full width for CLZ and CTZ
    always_comb begin : count_select
        case (issue.opcode)
            COUNT_CLZ, COUNT_CTZ: begin
                count_d = all_zero ? bit_count_t'(bmu_data_width) : bit_count_t'(lz_count);
            end
            COUNT_CPOP: count_d = pop_count;
            default:    count_d = '0;
        endcase
    end : count_select

    always_ff @(posedge clk_i) begin : count_stage
        if (issue.clk_en) begin
            count_o <= count_d;
        end
    end : count_stage

endmodule : bmu_bit_count

`default_nettype wire

// ==== rtl/bmu_lzc.sv ====
// Parameterized leading-zero counter built as a halving tree, with all-zero flag
`timescale 1ns/1ps
`default_nettype none

module bmu_lzc #(
    parameter int unsigned WIDTH = bmu_pkg::bmu_data_width,
    localparam type lz_count_t = logic [$clog2(WIDTH)-1:0]
) (
    input  logic [WIDTH-1:0] operand_i,
    output lz_count_t        lz_count_o,
    output logic             all_zero_o
);

    localparam int unsigned LEVELS = $clog2(WIDTH);

    // Operand as seen by each level, already shifted by the upper levels
    wire [WIDTH-1:0]  window [LEVELS];
    // One count bit per level, MSB decided first
    wire [LEVELS-1:0] upper_zero;

    assign window[0] = operand_i;

    //======================================================================
    // Halving tree
    //======================================================================

    // Each level tests the top half of the remaining window
    // A zero half adds that half to the count and is shifted out
    for (genvar s = 0; s < LEVELS; s++) begin : g_level
        localparam int unsigned HALF = WIDTH >> (s + 1);

        assign upper_zero[LEVELS-1-s] = (window[s][WIDTH-1 -: HALF] == '0);

        // Last level only decides the LSB, no further window
        if (s < LEVELS - 1) begin : g_shift
            assign window[s+1] = upper_zero[LEVELS-1-s] ? (window[s] << HALF) : window[s];
        end
    end

    assign lz_count_o = lz_count_t'(upper_zero);

    // Count field tops out at WIDTH-1, so zero operand is reported here
    assign all_zero_o = ~|operand_i;

endmodule : bmu_lzc

`default_nettype wire

// ==== rtl/bmu_issue_if.sv ====
// Issue interface carrying operands, opcode and clock enable to the execution groups
`timescale 1ns/1ps
`default_nettype none

interface bmu_issue_if;

    // Operands of the issued operation
    bmu_pkg::data_word_t  operand_a;
    bmu_pkg::data_word_t  operand_b;

    // Operation within the selected group
    bmu_pkg::bmu_opcode_t opcode;

    // Stage enable shared by every group register
    logic                 clk_en;

    // Driven from the top-level ports
    modport source (
        output operand_a,
        output operand_b,
        output opcode,
        output clk_en
    );

    // Seen by the execution groups
    modport exec (
        input operand_a,
        input operand_b,
        input opcode,
        input clk_en
    );

endinterface : bmu_issue_if

`default_nettype wire

// ==== rtl/bmu_pkg.sv ====
// Bit manipulation unit package with data path widths, word types, group and opcode codes
`default_nettype none

package bmu_pkg;

    //======================================================================
    // Data path widths
    //======================================================================

    // One data word
    localparam int unsigned bmu_data_width  = 32;
    // Bit position or shift index
    localparam int unsigned bmu_index_width = $clog2(bmu_data_width);
    // Bit count from 0 up to and including the word width
    localparam int unsigned bmu_count_width = $clog2(bmu_data_width) + 1;

    //======================================================================
    // Word and count types
    //======================================================================

    typedef logic [bmu_data_width-1:0]  data_word_t;
    typedef logic [bmu_count_width-1:0] bit_count_t;
    typedef logic [bmu_index_width-1:0] bit_index_t;

    // Leading-zero count as produced by the zero counter
    // All-zero operand is flagged on its own
    typedef logic [bmu_index_width-1:0] lz_count_t;

    //======================================================================
    // Operation group and opcode encodings
    //======================================================================

    typedef logic [1:0] bmu_group_t;

    localparam bmu_group_t GRP_SHADD   = 2'd0;
    localparam bmu_group_t GRP_LOGIC   = 2'd1;
    localparam bmu_group_t GRP_COUNT   = 2'd2;
    localparam bmu_group_t GRP_COMPARE = 2'd3;

    typedef logic [2:0] bmu_opcode_t;

    // Shift-and-add, value doubles as the left shift of operand A
    // Opcode 0 is a plain add
    localparam bmu_opcode_t SHADD_SH1 = 3'd1;
    localparam bmu_opcode_t SHADD_SH2 = 3'd2;
    localparam bmu_opcode_t SHADD_SH3 = 3'd3;

    // Logic and single-bit operations
    localparam bmu_opcode_t LOGIC_ANDN = 3'd0;
    localparam bmu_opcode_t LOGIC_ORN  = 3'd1;
    localparam bmu_opcode_t LOGIC_XNOR = 3'd2;
    localparam bmu_opcode_t LOGIC_BCLR = 3'd3;
    localparam bmu_opcode_t LOGIC_BEXT = 3'd4;
    localparam bmu_opcode_t LOGIC_BINV = 3'd5;
    localparam bmu_opcode_t LOGIC_BSET = 3'd6;

    // Bit counting
    localparam bmu_opcode_t COUNT_CLZ  = 3'd0;
    localparam bmu_opcode_t COUNT_CTZ  = 3'd1;
    localparam bmu_opcode_t COUNT_CPOP = 3'd2;

    // Signed and unsigned min/max
    localparam bmu_opcode_t CMP_MAX  = 3'd0;
    localparam bmu_opcode_t CMP_MAXU = 3'd1;
    localparam bmu_opcode_t CMP_MIN  = 3'd2;
    localparam bmu_opcode_t CMP_MINU = 3'd3;

endpackage : bmu_pkg

`default_nettype wire
